// File: logic/tcb_pkg.sv
////////////////////////////////////////
// tightly coupled bus subsystem package
// bus widths, manager count, memory depth
// and response timing shared by all blocks
////////////////////////////////////////

`default_nettype none

package tcb_pkg;

  ////////////////////////////////////////
  // interconnect
  ////////////////////////////////////////

  // number of manager ports
  localparam int unsigned TCB_PN = 2;
  // manager select width
  localparam int unsigned TCB_PL = $clog2(TCB_PN);

  ////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////

  // byte address
  localparam int unsigned TCB_ABW = 12;
  // data bus
  localparam int unsigned TCB_DBW = 32;
  // one enable per data byte
  localparam int unsigned TCB_BEW = TCB_DBW / 8;
  // response follows transfer by this many cycles
  localparam int unsigned TCB_DLY = 1;

  ////////////////////////////////////////
  // memory
  ////////////////////////////////////////

  // depth in words, 1 KiB total
  localparam int unsigned MEM_WORDS = 256;
  // word index width
  localparam int unsigned MEM_AW = $clog2(MEM_WORDS);

endpackage : tcb_pkg

`default_nettype wire

// File: logic/tcb_arbiter.sv
////////////////////////////////////////
// round-robin arbiter
// grants one manager at a time, keeps the
// grant during locked sequences and while
// a selected request waits for ready
////////////////////////////////////////

`default_nettype none

module tcb_arbiter import tcb_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  // requests from managers
  input  logic [TCB_PN-1:0] vld,
  // lock bit of the granted request
  input  logic              lck,
  // granted request accepted
  input  logic              trn,
  output logic [TCB_PL-1:0] sel
);

  // last manager served
  logic [TCB_PL-1:0] lst;
  // lock owner active, owner is lst
  logic              own;
  // selected request still waiting
  logic              pnd;
  logic [TCB_PL-1:0] pnd_sel;
  // round-robin candidate
  logic [TCB_PL-1:0] rr_sel;

  ////////////////////////////////////////
  // selection
  ////////////////////////////////////////

  // scan from farthest to nearest after lst,
  // nearest requester wins, lst itself last
  always_comb begin
    rr_sel = lst;
    for (int i = TCB_PN; i >= 1; i--) begin
      if (vld[(int'(lst) + i) % TCB_PN]) begin
        rr_sel = TCB_PL'((int'(lst) + i) % TCB_PN);
      end
    end
  end

  // lock first, then a waiting request
  always_comb begin
    if (own) begin
      sel = lst;
    end else if (pnd) begin
      sel = pnd_sel;
    end else begin
      sel = rr_sel;
    end
  end

  ////////////////////////////////////////
  // state
  ////////////////////////////////////////

  // priority starts at manager 0
  always_ff @(posedge clk) begin
    if (rst) begin
      lst <= TCB_PL'(TCB_PN - 1);
      own <= 1'b0;
      pnd <= 1'b0;
    end else if (trn) begin
      lst <= sel;
      own <= lck;
      pnd <= 1'b0;
    end else begin
      // hold grant on a back-pressured request
      pnd <= vld[sel];
    end
  end

  always_ff @(posedge clk) begin
    pnd_sel <= sel;
  end

endmodule : tcb_arbiter

`default_nettype wire

// File: logic/tcb_multiplexer.sv
////////////////////////////////////////
// bus multiplexer
// forwards the granted manager request to
// the subordinate and routes the response
// back to the manager that was accepted
////////////////////////////////////////

`default_nettype none

module tcb_multiplexer import tcb_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  // grant from arbiter
  input  logic [TCB_PL-1:0]  sel,
  // manager side requests
  input  logic [TCB_PN-1:0]  sub_vld,
  input  logic [TCB_PN-1:0]  sub_wen,
  input  logic [TCB_PN-1:0]  sub_lck,
  input  logic [TCB_ABW-1:0] sub_adr [TCB_PN-1:0],
  input  logic [TCB_BEW-1:0] sub_ben [TCB_PN-1:0],
  input  logic [TCB_DBW-1:0] sub_wdt [TCB_PN-1:0],
  // manager side responses
  output logic [TCB_PN-1:0]  sub_rdy,
  output logic [TCB_DBW-1:0] sub_rdt [TCB_PN-1:0],
  output logic [TCB_PN-1:0]  sub_err,
  // subordinate side request
  output logic               man_vld,
  output logic               man_wen,
  output logic               man_lck,
  output logic [TCB_ABW-1:0] man_adr,
  output logic [TCB_BEW-1:0] man_ben,
  output logic [TCB_DBW-1:0] man_wdt,
  // subordinate side response
  input  logic               man_rdy,
  input  logic [TCB_DBW-1:0] man_rdt,
  input  logic               man_err,
  // transfer and lock to arbiter
  output logic               trn,
  output logic               lck_sel
);

  // manager owning the response cycle
  logic [TCB_PL-1:0] rsp_sel;
  // response cycle active
  logic              rsp_vld;

  ////////////////////////////////////////
  // request path
  ////////////////////////////////////////

  // combinational, selected manager only
  assign man_vld = sub_vld[sel];
  assign man_wen = sub_wen[sel];
  assign man_lck = sub_lck[sel];
  assign man_adr = sub_adr[sel];
  assign man_ben = sub_ben[sel];
  assign man_wdt = sub_wdt[sel];

  assign lck_sel = sub_lck[sel];

  // handshake on the selected request
  assign trn = man_vld & man_rdy;

  ////////////////////////////////////////
  // response select
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_sel <= '0;
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= trn;
      if (trn) begin
        rsp_sel <= sel;
      end
    end
  end

  ////////////////////////////////////////
  // response path
  ////////////////////////////////////////

  for (genvar i = 0; i < TCB_PN; i++) begin : gen_rsp
    // ready only to the granted manager
    assign sub_rdy[i] = (sel == TCB_PL'(i)) & man_rdy;
    // data and error only on own response cycle
    assign sub_rdt[i] = (rsp_vld && rsp_sel == TCB_PL'(i)) ? man_rdt : '0;
    assign sub_err[i] = rsp_vld && (rsp_sel == TCB_PL'(i)) && man_err;
  end : gen_rsp

endmodule : tcb_multiplexer

`default_nettype wire

// File: logic/tcb_memory.sv
////////////////////////////////////////
// byte-enabled word memory subordinate
// one-cycle response, error above its size
// and a wait cycle after each write
////////////////////////////////////////

`default_nettype none

module tcb_memory import tcb_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  // request
  input  logic               vld,
  input  logic               wen,
  input  logic [TCB_ABW-1:0] adr,
  input  logic [TCB_BEW-1:0] ben,
  input  logic [TCB_DBW-1:0] wdt,
  // handshake and response
  output logic               rdy,
  output logic [TCB_DBW-1:0] rdt,
  output logic               err
);

  // storage
  logic [TCB_DBW-1:0] mem [MEM_WORDS];

  // accepted request
  logic              trn;
  // address inside memory
  logic              in_rng;
  // word index
  logic [MEM_AW-1:0] wrd;

  assign trn    = vld & rdy;
  assign in_rng = adr < TCB_ABW'(MEM_WORDS * TCB_BEW);
  assign wrd    = MEM_AW'(adr / TCB_BEW);

  ////////////////////////////////////////
  // handshake
  ////////////////////////////////////////

  // low in reset, low for one cycle after a write
  always_ff @(posedge clk) begin
    if (rst) begin
      rdy <= 1'b0;
      err <= 1'b0;
    end else begin
      rdy <= ~(trn & wen);
      err <= trn & ~in_rng;
    end
  end

  ////////////////////////////////////////
  // write
  ////////////////////////////////////////

  // enabled bytes only, nothing out of range
  always_ff @(posedge clk) begin
    if (trn && wen && in_rng) begin
      for (int b = 0; b < TCB_BEW; b++) begin
        if (ben[b]) begin
          mem[wrd][8*b +: 8] <= wdt[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////
  // read
  ////////////////////////////////////////

  // zero for writes and out of range reads
  always_ff @(posedge clk) begin
    if (trn) begin
      rdt <= (!wen && in_rng) ? mem[wrd] : '0;
    end
  end

endmodule : tcb_memory

`default_nettype wire

// File: logic/tcb_subsystem_top.sv
////////////////////////////////////////
// shared memory subsystem top
// two managers arbitrated onto one memory
////////////////////////////////////////

`default_nettype none

module tcb_subsystem_top import tcb_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  // manager 0
  input  logic               m0_vld,
  input  logic               m0_wen,
  input  logic               m0_lck,
  input  logic [TCB_ABW-1:0] m0_adr,
  input  logic [TCB_BEW-1:0] m0_ben,
  input  logic [TCB_DBW-1:0] m0_wdt,
  output logic               m0_rdy,
  output logic [TCB_DBW-1:0] m0_rdt,
  output logic               m0_err,
  // manager 1
  input  logic               m1_vld,
  input  logic               m1_wen,
  input  logic               m1_lck,
  input  logic [TCB_ABW-1:0] m1_adr,
  input  logic [TCB_BEW-1:0] m1_ben,
  input  logic [TCB_DBW-1:0] m1_wdt,
  output logic               m1_rdy,
  output logic [TCB_DBW-1:0] m1_rdt,
  output logic               m1_err
);

  ////////////////////////////////////////
  // manager vectors
  ////////////////////////////////////////

  logic [TCB_PN-1:0]  sub_vld;
  logic [TCB_PN-1:0]  sub_wen;
  logic [TCB_PN-1:0]  sub_lck;
  logic [TCB_ABW-1:0] sub_adr [TCB_PN-1:0];
  logic [TCB_BEW-1:0] sub_ben [TCB_PN-1:0];
  logic [TCB_DBW-1:0] sub_wdt [TCB_PN-1:0];
  logic [TCB_PN-1:0]  sub_rdy;
  logic [TCB_DBW-1:0] sub_rdt [TCB_PN-1:0];
  logic [TCB_PN-1:0]  sub_err;

  // index 0 is manager 0
  assign sub_vld = {m1_vld, m0_vld};
  assign sub_wen = {m1_wen, m0_wen};
  assign sub_lck = {m1_lck, m0_lck};
  assign sub_adr[0] = m0_adr;
  assign sub_adr[1] = m1_adr;
  assign sub_ben[0] = m0_ben;
  assign sub_ben[1] = m1_ben;
  assign sub_wdt[0] = m0_wdt;
  assign sub_wdt[1] = m1_wdt;

  assign m0_rdy = sub_rdy[0];
  assign m1_rdy = sub_rdy[1];
  assign m0_rdt = sub_rdt[0];
  assign m1_rdt = sub_rdt[1];
  assign m0_err = sub_err[0];
  assign m1_err = sub_err[1];

  ////////////////////////////////////////
  // interconnect
  ////////////////////////////////////////

  logic [TCB_PL-1:0]  sel;
  logic               trn;
  logic               lck_sel;
  // subordinate bus
  logic               man_vld;
  logic               man_wen;
  logic [TCB_ABW-1:0] man_adr;
  logic [TCB_BEW-1:0] man_ben;
  logic [TCB_DBW-1:0] man_wdt;
  logic               man_rdy;
  logic [TCB_DBW-1:0] man_rdt;
  logic               man_err;

  tcb_arbiter u_arbiter (
    .clk (clk),
    .rst (rst),
    .vld (sub_vld),
    .lck (lck_sel),
    .trn (trn),
    .sel (sel)
  );

  tcb_multiplexer u_multiplexer (
    .clk     (clk),
    .rst     (rst),
    .sel     (sel),
    .sub_vld (sub_vld),
    .sub_wen (sub_wen),
    .sub_lck (sub_lck),
    .sub_adr (sub_adr),
    .sub_ben (sub_ben),
    .sub_wdt (sub_wdt),
    .sub_rdy (sub_rdy),
    .sub_rdt (sub_rdt),
    .sub_err (sub_err),
    .man_vld (man_vld),
    .man_wen (man_wen),
    .man_lck (),
    .man_adr (man_adr),
    .man_ben (man_ben),
    .man_wdt (man_wdt),
    .man_rdy (man_rdy),
    .man_rdt (man_rdt),
    .man_err (man_err),
    .trn     (trn),
    .lck_sel (lck_sel)
  );

  // lock is consumed by the arbiter, not the memory
  tcb_memory u_memory (
    .clk (clk),
    .rst (rst),
    .vld (man_vld),
    .wen (man_wen),
    .adr (man_adr),
    .ben (man_ben),
    .wdt (man_wdt),
    .rdy (man_rdy),
    .rdt (man_rdt),
    .err (man_err)
  );

endmodule : tcb_subsystem_top

`default_nettype wire

// File: verif/tcb_subsystem_checker.sv
////////////////////////////////////////
// bus rule checker for the subsystem
// handshake, grant, lock, back-pressure
// and response routing assertions
////////////////////////////////////////

`default_nettype none

module tcb_subsystem_checker import tcb_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic [TCB_PN-1:0]  sub_vld,
  input  logic [TCB_PN-1:0]  sub_wen,
  input  logic [TCB_PN-1:0]  sub_lck,
  input  logic [TCB_ABW-1:0] sub_adr [TCB_PN-1:0],
  input  logic [TCB_BEW-1:0] sub_ben [TCB_PN-1:0],
  input  logic [TCB_DBW-1:0] sub_wdt [TCB_PN-1:0],
  input  logic [TCB_PN-1:0]  sub_rdy,
  input  logic [TCB_DBW-1:0] sub_rdt [TCB_PN-1:0],
  input  logic [TCB_PN-1:0]  sub_err
);

  timeunit 1ns;
  timeprecision 100ps;

  // failed assertions so far
  int unsigned fail_cnt = 0;

  // transfer per manager
  logic [TCB_PN-1:0] acc;

  assign acc = sub_vld & sub_rdy;

  ////////////////////////////////////////
  // shared rules
  ////////////////////////////////////////

  // quiet bus during and right after reset
  a_reset : assert property (@(posedge clk) rst |=> (sub_rdy == '0) && (sub_err == '0))
    else begin $error("ready or error high during reset"); fail_cnt++; end

  // one grant at a time
  a_one_rdy : assert property (@(posedge clk) disable iff (rst) $onehot0(sub_rdy))
    else begin $error("more than one manager saw ready"); fail_cnt++; end

  // wait cycle after every write
  a_wr_wait : assert property (@(posedge clk) disable iff (rst)
    |(acc & sub_wen) |=> (sub_rdy == '0))
    else begin $error("ready high on the cycle after a write"); fail_cnt++; end

  ////////////////////////////////////////
  // per manager rules
  ////////////////////////////////////////

  for (genvar i = 0; i < TCB_PN; i++) begin : gen_mgr
    // the competing manager
    localparam int O = (i + 1) % TCB_PN;

    // error only on own response cycle
    a_err_own : assert property (@(posedge clk) disable iff (rst)
      sub_err[i] |-> $past(acc[i], TCB_DLY))
      else begin $error("error without an own transfer"); fail_cnt++; end

    // no stray read data
    a_rdt_zero : assert property (@(posedge clk) disable iff (rst)
      !$past(acc[i], TCB_DLY) |-> (sub_rdt[i] == '0))
      else begin $error("read data outside own response cycle"); fail_cnt++; end

    // unlocked transfer hands over to a waiting peer
    a_rr : assert property (@(posedge clk) disable iff (rst)
      acc[i] && !sub_lck[i] && sub_vld[O] |=> !acc[i] until acc[O])
      else begin $error("round-robin turn skipped"); fail_cnt++; end

    // peer locked out until the unlocking transfer
    a_lock : assert property (@(posedge clk) disable iff (rst)
      acc[i] && sub_lck[i] |=> !acc[O] until (acc[i] && !sub_lck[i]))
      else begin $error("transfer broke into a locked sequence"); fail_cnt++; end

    // waiting request held stable
    a_hold : assert property (@(posedge clk) disable iff (rst)
      sub_vld[i] && !sub_rdy[i] |=> sub_vld[i] && $stable(sub_wen[i])
        && $stable(sub_adr[i]) && $stable(sub_ben[i]) && $stable(sub_wdt[i]))
      else begin $error("waiting request changed before ready"); fail_cnt++; end

    // address past the memory end
    a_oor : assert property (@(posedge clk) disable iff (rst)
      acc[i] && (sub_adr[i] >= MEM_WORDS * TCB_BEW) |-> ##TCB_DLY sub_err[i])
      else begin $error("no error for an out of range access"); fail_cnt++; end
  end : gen_mgr

endmodule : tcb_subsystem_checker

`default_nettype wire

// File: verif/tcb_subsystem_tb.sv
////////////////////////////////////////
// shared memory subsystem testbench
// two managers, word model of the memory
////////////////////////////////////////

`default_nettype none

module tcb_subsystem_tb import tcb_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  logic               clk;
  logic               rst;
  // manager requests, index is manager
  logic [1:0]         vld;
  logic [1:0]         wen;
  logic [1:0]         lck;
  logic [TCB_ABW-1:0] adr [2];
  logic [TCB_BEW-1:0] ben [2];
  logic [TCB_DBW-1:0] wdt [2];
  // manager responses
  wire  [1:0]         rdy;
  wire  [TCB_DBW-1:0] rdt [2];
  wire  [1:0]         err;

  // expected memory contents
  logic [TCB_DBW-1:0] model [MEM_WORDS];
  logic [TCB_ABW-1:0] a;

  tcb_subsystem_top dut_i (
    .clk (clk), .rst (rst),
    .m0_vld (vld[0]), .m0_wen (wen[0]), .m0_lck (lck[0]), .m0_adr (adr[0]),
    .m0_ben (ben[0]), .m0_wdt (wdt[0]), .m0_rdy (rdy[0]), .m0_rdt (rdt[0]),
    .m0_err (err[0]),
    .m1_vld (vld[1]), .m1_wen (wen[1]), .m1_lck (lck[1]), .m1_adr (adr[1]),
    .m1_ben (ben[1]), .m1_wdt (wdt[1]), .m1_rdy (rdy[1]), .m1_rdt (rdt[1]),
    .m1_err (err[1])
  );

  bind tcb_subsystem_top tcb_subsystem_checker chk_i (
    .clk (clk), .rst (rst),
    .sub_vld (sub_vld), .sub_wen (sub_wen), .sub_lck (sub_lck),
    .sub_adr (sub_adr), .sub_ben (sub_ben), .sub_wdt (sub_wdt),
    .sub_rdy (sub_rdy), .sub_rdt (sub_rdt), .sub_err (sub_err)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  // enabled bytes replaced, the rest kept
  function automatic logic [TCB_DBW-1:0] merge_bytes(input logic [TCB_DBW-1:0] old,
      input logic [TCB_DBW-1:0] nxt, input logic [TCB_BEW-1:0] be);
    logic [TCB_DBW-1:0] res;
    res = old;
    for (int b = 0; b < TCB_BEW; b++) begin
      if (be[b]) res[8*b +: 8] = nxt[8*b +: 8];
    end
    return res;
  endfunction

  function automatic logic [TCB_ABW-1:0] random_word();
    return TCB_ABW'($urandom_range(MEM_WORDS - 1) * TCB_BEW);
  endfunction

  // one request, held until ready, response checked
  task automatic bus_access(input int m, input logic w, input logic l,
      input logic [TCB_ABW-1:0] ad, input logic [TCB_BEW-1:0] be,
      input logic [TCB_DBW-1:0] d);
    logic [TCB_DBW-1:0] exp_rdt;
    logic               in_rng;
    int                 idx;
    int                 cnt;
    in_rng = ad < MEM_WORDS * TCB_BEW;
    idx    = int'(ad) / TCB_BEW;
    cnt    = 0;
    @(posedge clk);
    vld[m] <= 1'b1;
    wen[m] <= w;
    lck[m] <= l;
    adr[m] <= ad;
    ben[m] <= be;
    wdt[m] <= d;
    @(negedge clk);
    while (!rdy[m]) begin
      cnt++;
      if (cnt > 50) abort_run($sformatf("ready never came for manager %0d", m));
      @(negedge clk);
    end
    // accepted on the coming edge
    exp_rdt = in_rng ? model[idx] : '0;
    if (w && in_rng) model[idx] = merge_bytes(model[idx], d, be);
    @(posedge clk);
    vld[m] <= 1'b0;
    @(negedge clk);
    if (err[m] !== !in_rng) begin
      abort_run($sformatf("Error m%0d_err expected 0x%h actual 0x%h", m, !in_rng, err[m]));
    end
    if (!w && rdt[m] !== exp_rdt) begin
      abort_run($sformatf("Error m%0d_rdt expected 0x%h actual 0x%h", m, exp_rdt, rdt[m]));
    end
  endtask

  // full write, partial write, read back, random words
  task automatic mixed_traffic(input int m, input int n);
    logic [TCB_ABW-1:0] ad;
    for (int k = 0; k < n; k++) begin
      ad = random_word();
      bus_access(m, 1'b1, 1'b0, ad, '1, $urandom());
      bus_access(m, 1'b1, 1'b0, ad, TCB_BEW'($urandom()), $urandom());
      bus_access(m, 1'b0, 1'b0, ad, '1, '0);
    end
  endtask

  // any failed assertion ends the run
  always @(negedge clk) begin
    if (dut_i.chk_i.fail_cnt != 0) abort_run("a bus rule assertion failed");
  end

  initial begin
    void'($urandom(32'hbf06_03b9));
    rst = 1'b1;
    vld = '0;
    wen = '0;
    lck = '0;
    for (int m = 0; m < 2; m++) begin
      adr[m] = '0;
      ben[m] = '0;
      wdt[m] = '0;
    end
    for (int i = 0; i < MEM_WORDS; i++) model[i] = 'x;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // byte enables, one manager at a time
    for (int m = 0; m < 2; m++) begin
      for (int n = 0; n < 4; n++) begin
        a = random_word();
        bus_access(m, 1'b1, 1'b0, a, '1, $urandom());
        bus_access(m, 1'b1, 1'b0, a, TCB_BEW'($urandom()), $urandom());
        bus_access(m, 1'b0, 1'b0, a, '1, '0);
      end
    end

    // both managers competing
    fork
      mixed_traffic(0, 6);
      mixed_traffic(1, 6);
    join

    // locked sequence from manager 0
    a = random_word();
    fork
      begin
        bus_access(0, 1'b1, 1'b1, a, '1, $urandom());
        bus_access(0, 1'b0, 1'b1, a, '1, '0);
        bus_access(0, 1'b1, 1'b1, a, TCB_BEW'($urandom()), $urandom());
        bus_access(0, 1'b0, 1'b0, a, '1, '0);
      end
      begin
        repeat (3) @(posedge clk);
        bus_access(1, 1'b0, 1'b0, a, '1, '0);
      end
    join

    // past the end of memory
    bus_access(1, 1'b1, 1'b0, 12'h000, '1, $urandom());
    bus_access(0, 1'b1, 1'b0, 12'h400, '1, $urandom());
    bus_access(1, 1'b0, 1'b0, 12'h400, '1, '0);
    bus_access(1, 1'b0, 1'b0, 12'hffc, '1, '0);
    // word 0 is where 12'h400 would wrap to
    bus_access(0, 1'b0, 1'b0, 12'h000, '1, '0);

    repeat (2) @(posedge clk);
    if (dut_i.chk_i.fail_cnt != 0) begin
      abort_run("a bus rule assertion failed");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule : tcb_subsystem_tb

`default_nettype wire

// File: filelist.f
logic/tcb_pkg.sv
logic/tcb_arbiter.sv
logic/tcb_multiplexer.sv
logic/tcb_memory.sv
logic/tcb_subsystem_top.sv
verif/tcb_subsystem_checker.sv
verif/tcb_subsystem_tb.sv
